/* include/window_config.svh */
// Image and window geometry for the window fetcher, included by the RTL and the testbench
`ifndef WINDOW_CONFIG_SVH
`define WINDOW_CONFIG_SVH

// **************************************************
// Basic parameters
// **************************************************
`define WF_PIXEL_W      8
`define WF_IMAGE_W      8
`define WF_IMAGE_H      6
`define WF_WIN_W        3
`define WF_WIN_H        3
`define WF_COL_OFFSET   0
`define WF_ROW_OFFSET   0
`define WF_BORDER_CONST 8'hA5

// **************************************************
// Derived centre constants
// **************************************************
`define WF_CENTER_COL   (((`WF_WIN_W - 1) / 2) + `WF_COL_OFFSET) // Centre tap inside the window
`define WF_CENTER_ROW   (((`WF_WIN_H - 1) / 2) + `WF_ROW_OFFSET)

// Distance from the centre to the newest tap
`define WF_REV_COL      ((`WF_WIN_W - 1) - `WF_CENTER_COL)
`define WF_REV_ROW      ((`WF_WIN_H - 1) - `WF_CENTER_ROW)

`define WF_START_COL    ((`WF_IMAGE_W - 1) - `WF_REV_COL) // Counter position out of reset
`define WF_START_ROW    ((`WF_IMAGE_H - 1) - `WF_REV_ROW)

`endif

/* src/window_pkg.sv */
// Shared pixel, coordinate and FSM state types, imported by every window fetcher module
`default_nettype none

`include "window_config.svh"

package window_pkg;

    // **************************************************
    // Data types
    // **************************************************

    // One image pixel
    typedef logic [`WF_PIXEL_W-1:0] pixel_t;

    // Image column or row of the window centre
    typedef logic [15:0] coord_t;

    // **************************************************
    // Prime FSM states
    // **************************************************
    typedef enum logic {
        PRIME,  // Window not yet filled
        STREAM  // Every push emits a window
    } prime_state_e;

endpackage

`default_nettype wire

/* src/center_position_counter.sv */
// Raster counter for the window centre position, advanced on each push and resynced by frame start
`timescale 1ns/1ps
`default_nettype none

`include "window_config.svh"

module center_position_counter (
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   push_i,
    input  wire                   sof_i,
    output window_pkg::coord_t    col_o,
    output window_pkg::coord_t    row_o,
    output logic                  at_last_o
);
    import window_pkg::*;

    // Position that follows the start position, loaded on the first pixel of a frame
    localparam int SyncCol = (`WF_START_COL == `WF_IMAGE_W - 1) ? 0 : `WF_START_COL + 1;
    localparam int SyncRow = (`WF_START_COL != `WF_IMAGE_W - 1) ? `WF_START_ROW :
                             (`WF_START_ROW == `WF_IMAGE_H - 1) ? 0 : `WF_START_ROW + 1;

    coord_t col_q;
    coord_t row_q;
    coord_t col_d;
    coord_t row_d;
    logic   last_col;
    logic   last_row;

    assign last_col  = (col_q == coord_t'(`WF_IMAGE_W - 1));
    assign last_row  = (row_q == coord_t'(`WF_IMAGE_H - 1));
    assign at_last_o = last_col && last_row; // Centre sits on the last image pixel

    always_comb begin
        col_d = col_q;
        row_d = row_q;
        if (push_i) begin
            if (sof_i) begin
                col_d = coord_t'(SyncCol);  // Realign to the new frame
                row_d = coord_t'(SyncRow);
            end else if (last_col) begin
                col_d = '0;
                row_d = last_row ? '0 : row_q + 16'd1; // Wrap into the next frame
            end else begin
                col_d = col_q + 16'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            col_q <= coord_t'(`WF_START_COL);
            row_q <= coord_t'(`WF_START_ROW);
        end else begin
            col_q <= col_d;
            row_q <= row_d;
        end
    end

    assign col_o = col_q;
    assign row_o = row_q;

endmodule

`default_nettype wire

/* src/window_prime_fsm.sv */
// Prime state machine that holds output off until the first valid centre, then emits per push
`timescale 1ns/1ps
`default_nettype none

module window_prime_fsm (
    input  wire  clk_i,
    input  wire  rst_i,
    input  wire  push_i,
    input  wire  at_last_i,
    output logic emit_o
);
    import window_pkg::*;

    prime_state_e state_q;
    prime_state_e state_d;
    logic         emit_d;

    // **************************************************
    // Next state
    // **************************************************
    always_comb begin
        state_d = state_q;
        emit_d  = 1'b0;
        case (state_q)
            PRIME: begin
                // The push that wraps the centre to (0,0) is the first valid one
                if (push_i && at_last_i) begin
                    state_d = STREAM;
                    emit_d  = 1'b1;
                end
            end
            STREAM: begin
                emit_d = push_i;          // One emit strobe per push
            end
            default: begin
                state_d = PRIME;
            end
        endcase
    end

    // **************************************************
    // State and strobe registers
    // **************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= PRIME;
            emit_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            emit_o  <= emit_d;            // High for one cycle after the push edge
        end
    end

endmodule

`default_nettype wire

/* src/line_buffer.sv */
// Circular row buffer that hands out, on each push, the pixel written one image row earlier
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
    parameter int DEPTH = 8
) (
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   push_i,
    input  wire window_pkg::pixel_t data_i,
    output window_pkg::pixel_t    data_o
);
    import window_pkg::*;

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    pixel_t          mem_q [DEPTH];
    logic [PtrW-1:0] ptr_q;
    logic [PtrW-1:0] ptr_next;

    assign ptr_next = (ptr_q == PtrW'(DEPTH - 1)) ? '0 : ptr_q + PtrW'(1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else if (push_i) begin
            ptr_q <= ptr_next;
        end
    end

    // Read the slot the next push overwrites, so the registered tap is a
    // full row old by the time the window consumes it
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[ptr_q] <= data_i;
            data_o       <= mem_q[ptr_next];
        end
    end

endmodule

`default_nettype wire

/* src/window_shift_array.sv */
// Input register and window shift array fed by the line buffers, presented upright to the border stage
`timescale 1ns/1ps
`default_nettype none

`include "window_config.svh"

module window_shift_array (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire window_pkg::pixel_t data_i,
    input  wire                     valid_i,
    input  wire                     frame_start_i,
    input  wire window_pkg::pixel_t tap_i     [`WF_WIN_H-1],
    output logic                    push_o,
    output logic                    sof_o,
    output window_pkg::pixel_t      line_in_o [`WF_WIN_H-1],
    output window_pkg::pixel_t      window_o  [`WF_WIN_H][`WF_WIN_W]
);
    import window_pkg::*;

    pixel_t data_q;
    logic   push_q;
    logic   sof_q;

    // Column 0 holds the newest pixel of each row, row 0 the newest row
    pixel_t win_rev_q [`WF_WIN_H][`WF_WIN_W];

    // **************************************************
    // Input register
    // **************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            push_q <= 1'b0;
            sof_q  <= 1'b0;
        end else begin
            push_q <= valid_i;
            sof_q  <= valid_i && frame_start_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= data_i;
    end

    assign push_o = push_q;
    assign sof_o  = sof_q;

    // **************************************************
    // Shift registers
    // **************************************************
    always_ff @(posedge clk_i) begin
        if (push_q) begin
            win_rev_q[0][0] <= data_q;
            for (int r = 1; r < `WF_WIN_H; r++) begin
                win_rev_q[r][0] <= tap_i[r-1]; // Older rows come out of the buffers
            end
            for (int r = 0; r < `WF_WIN_H; r++) begin
                for (int c = 1; c < `WF_WIN_W; c++) begin
                    win_rev_q[r][c] <= win_rev_q[r][c-1];
                end
            end
        end
    end

    // Each buffer stores what enters the newest column of its row
    assign line_in_o[0] = data_q;
    for (genvar b = 1; b < `WF_WIN_H - 1; b++) begin : g_line_in
        assign line_in_o[b] = tap_i[b-1];
    end

    // Flip both axes so that [0][0] is the top-left neighbour
    for (genvar r = 0; r < `WF_WIN_H; r++) begin : g_row
        for (genvar c = 0; c < `WF_WIN_W; c++) begin : g_col
            assign window_o[r][c] = win_rev_q[`WF_WIN_H-1-r][`WF_WIN_W-1-c];
        end
    end

endmodule

`default_nettype wire

/* src/border_extend.sv */
// Output stage that registers the window and centre and replaces taps outside the image
`timescale 1ns/1ps
`default_nettype none

`include "window_config.svh"

module border_extend (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire window_pkg::pixel_t window_i [`WF_WIN_H][`WF_WIN_W],
    input  wire window_pkg::coord_t col_i,
    input  wire window_pkg::coord_t row_i,
    input  wire                     emit_i,
    output window_pkg::pixel_t      window_o [`WF_WIN_H][`WF_WIN_W],
    output window_pkg::coord_t      col_o,
    output window_pkg::coord_t      row_o,
    output logic                    valid_o
);
    import window_pkg::*;

    pixel_t win_q [`WF_WIN_H][`WF_WIN_W];
    coord_t col_q;
    coord_t row_q;
    logic   valid_q;

    // **************************************************
    // Output registers
    // **************************************************
    always_ff @(posedge clk_i) begin
        win_q <= window_i;
        col_q <= col_i;
        row_q <= row_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= emit_i;            // Pulses once per emitting push
        end
    end

    // **************************************************
    // Border substitution
    // **************************************************
    always_comb begin
        int img_row;
        int img_col;
        for (int r = 0; r < `WF_WIN_H; r++) begin
            for (int c = 0; c < `WF_WIN_W; c++) begin
                // Image position of this tap relative to the centre
                img_row = int'(row_q) + r - `WF_CENTER_ROW;
                img_col = int'(col_q) + c - `WF_CENTER_COL;
                if ((img_row < 0) || (img_row > `WF_IMAGE_H - 1) ||
                    (img_col < 0) || (img_col > `WF_IMAGE_W - 1)) begin
                    window_o[r][c] = pixel_t'(`WF_BORDER_CONST);
                end else begin
                    window_o[r][c] = win_q[r][c];
                end
            end
        end
    end

    assign col_o   = col_q;
    assign row_o   = row_q;
    assign valid_o = valid_q;

endmodule

`default_nettype wire

/* src/window_fetch_top.sv */
// Top level of the streaming window fetcher, wiring the counter, FSM, line buffers and output stage
`timescale 1ns/1ps
`default_nettype none

`include "window_config.svh"

module window_fetch_top (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire window_pkg::pixel_t data_i,
    input  wire                     valid_i,
    input  wire                     frame_start_i,
    output window_pkg::pixel_t      window_o [`WF_WIN_H][`WF_WIN_W],
    output window_pkg::coord_t      col_o,
    output window_pkg::coord_t      row_o,
    output logic                    valid_o
);
    import window_pkg::*;

    // **************************************************
    // Internal wires
    // **************************************************
    logic   push_q;                              // Registered push strobe
    logic   sof_q;                               // Registered frame start
    pixel_t line_in [`WF_WIN_H-1];
    pixel_t tap     [`WF_WIN_H-1];
    pixel_t window_upright [`WF_WIN_H][`WF_WIN_W];
    coord_t center_col;
    coord_t center_row;
    logic   at_last;
    logic   emit;

    window_shift_array u_shift_array (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .data_i        (data_i),
        .valid_i       (valid_i),
        .frame_start_i (frame_start_i),
        .tap_i         (tap),
        .push_o        (push_q),
        .sof_o         (sof_q),
        .line_in_o     (line_in),
        .window_o      (window_upright)
    );

    // One row buffer per window row above the newest one
    for (genvar b = 0; b < `WF_WIN_H - 1; b++) begin : g_line_buffer
        line_buffer #(
            .DEPTH (`WF_IMAGE_W)
        ) u_line_buffer (
            .clk_i  (clk_i),
            .rst_i  (rst_i),
            .push_i (push_q),
            .data_i (line_in[b]),
            .data_o (tap[b])
        );
    end

    center_position_counter u_center_counter (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .push_i    (push_q),
        .sof_i     (sof_q),
        .col_o     (center_col),
        .row_o     (center_row),
        .at_last_o (at_last)
    );

    window_prime_fsm u_prime_fsm (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .push_i    (push_q),
        .at_last_i (at_last),
        .emit_o    (emit)
    );

    border_extend u_border_extend (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .window_i (window_upright),
        .col_i    (center_col),
        .row_i    (center_row),
        .emit_i   (emit),
        .window_o (window_o),
        .col_o    (col_o),
        .row_o    (row_o),
        .valid_o  (valid_o)
    );

endmodule

`default_nettype wire

/* sim/window_fetch_properties.sv */
// Concurrent checks on the window fetcher outputs, bound into window_fetch_top by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "window_config.svh"

module window_fetch_properties (
    input wire                     clk_i,
    input wire                     rst_i,
    input wire                     valid_i,
    input wire window_pkg::coord_t col_o,
    input wire window_pkg::coord_t row_o,
    input wire                     valid_o
);

    int assert_errors = 0;                 // Read by the testbench at the end of the run

    // **************************************************
    // Output strobe
    // **************************************************

    // Quiet through reset and the first cycle after it
    a_reset_quiet: assert property (@(posedge clk_i) rst_i |=> !valid_o ##1 !valid_o)
        else begin
            assert_errors++;
            $error("valid_o high during reset or in the cycle after it");
        end

    // valid_o rises two edges after the edge that sampled the push
    a_valid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_o |-> $past(valid_i, 3))
        else begin
            assert_errors++;
            $error("valid_o without a push two cycles before");
        end

    // **************************************************
    // Centre position
    // **************************************************
    a_center_in_image: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_o |-> (col_o < `WF_IMAGE_W) && (row_o < `WF_IMAGE_H))
        else begin
            assert_errors++;
            $error("centre position outside the image while valid_o is high");
        end

endmodule

`default_nettype wire

/* sim/window_fetch_tb.sv */
// Testbench for the window fetcher that applies a stimulus table of frames and checks every window
`timescale 1ns/1ps
`default_nettype none

`include "window_config.svh"

module window_fetch_tb;
    import window_pkg::*;

    localparam int FramePix = `WF_IMAGE_W * `WF_IMAGE_H;
    localparam int RevDist  = `WF_REV_ROW * `WF_IMAGE_W + `WF_REV_COL;  // Newest pixel to centre
    localparam int StartIdx = `WF_START_ROW * `WF_IMAGE_W + `WF_START_COL;
    localparam int TruncPix = 29;                                       // Frame cut short
    localparam int TailPix  = RevDist + 1;
    localparam int NumStim  = 3 * FramePix + TruncPix + TailPix;

    logic   clk;
    logic   rst;
    pixel_t data;
    logic   valid;
    logic   frame_start;
    pixel_t dut_window [`WF_WIN_H][`WF_WIN_W];
    coord_t dut_col;
    coord_t dut_row;
    logic   dut_valid;

    // Stimulus table
    pixel_t stim_pixel [NumStim];
    int     stim_gap   [NumStim];
    logic   stim_sof   [NumStim];

    // Reference model state and expected results
    pixel_t stream_q [$];
    int     model_pos;
    logic   streaming;
    logic   skip_win;
    coord_t exp_col_q [$];
    coord_t exp_row_q [$];
    int     exp_due_q [$];
    logic   exp_chk_q [$];
    pixel_t exp_win_q [$];                 // WIN_H*WIN_W taps per window, row major

    int cycle = 0;
    int cycle_limit = 0;
    int error_count = 0;
    int windows_seen = 0;

    window_fetch_top u_dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .data_i        (data),
        .valid_i       (valid),
        .frame_start_i (frame_start),
        .window_o      (dut_window),
        .col_o         (dut_col),
        .row_o         (dut_row),
        .valid_o       (dut_valid)
    );

    bind window_fetch_top window_fetch_properties u_properties (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .col_o   (col_o),
        .row_o   (row_o),
        .valid_o (valid_o)
    );

    always #10 clk = ~clk;

    // Cycle counter and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if ((cycle_limit > 0) && (cycle >= cycle_limit)) begin
            $display("Timeout after %0d cycles, the pipeline did not drain", cycle);
            $display("Regression failed");
            $finish;
        end
    end

    // **************************************************
    // Compare tasks
    // **************************************************
    task automatic check_pixel(input string name, input pixel_t actual, input pixel_t expected);
        if (actual !== expected) begin
            $display("FAILED time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_coord(input string name, input coord_t actual, input coord_t expected);
        if (actual !== expected) begin
            $display("FAILED time=%0t %s actual=%0d expected=%0d", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED time=%0t %s actual=%b expected=%b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // **************************************************
    // Stimulus table and reference model
    // **************************************************
    task automatic build_table();
        int lens [5];
        int idx;
        int gap_sum;
        lens = '{FramePix, TruncPix, FramePix, FramePix, TailPix};
        idx = 0;
        gap_sum = 0;
        for (int f = 0; f < 5; f++) begin
            for (int p = 0; p < lens[f]; p++) begin
                stim_pixel[idx] = pixel_t'($urandom);
                if (stim_pixel[idx] == pixel_t'(`WF_BORDER_CONST)) begin
                    stim_pixel[idx] ^= pixel_t'(1);   // Keep image data apart from the border value
                end
                stim_gap[idx] = ($urandom % 2 == 0) ? 0 : int'($urandom % 4);
                stim_sof[idx] = (p == 0);
                gap_sum += stim_gap[idx];
                idx++;
            end
        end
        cycle_limit = 2 * (NumStim + gap_sum) + 100;
    endtask

    task automatic model_push(input pixel_t pix, input logic sof, input int due);
        int newest;
        int prev_pos;
        int center_idx;
        int c_row;
        int c_col;
        int img_r;
        int img_c;
        int tap_idx;
        stream_q.push_back(pix);
        newest = stream_q.size() - 1;
        prev_pos = model_pos;
        if (sof) begin
            if (prev_pos != StartIdx) begin
                skip_win = 1'b1;                // Previous frame was cut short
            end
            model_pos = (FramePix - RevDist) % FramePix;
        end else begin
            model_pos = (model_pos + 1) % FramePix;
        end
        if (!streaming && (model_pos == 0)) begin
            streaming = 1'b1;                   // First valid centre reached
        end
        if (streaming) begin
            c_row = model_pos / `WF_IMAGE_W;
            c_col = model_pos % `WF_IMAGE_W;
            if (skip_win && (c_row == `WF_REV_ROW) && (c_col == `WF_REV_COL)) begin
                skip_win = 1'b0;                // Window fully inside the new frame again
            end
            center_idx = newest - RevDist;
            exp_col_q.push_back(coord_t'(c_col));
            exp_row_q.push_back(coord_t'(c_row));
            exp_due_q.push_back(due);
            exp_chk_q.push_back(!skip_win);
            for (int r = 0; r < `WF_WIN_H; r++) begin
                for (int c = 0; c < `WF_WIN_W; c++) begin
                    img_r = c_row + r - `WF_CENTER_ROW;
                    img_c = c_col + c - `WF_CENTER_COL;
                    tap_idx = center_idx + (r - `WF_CENTER_ROW) * `WF_IMAGE_W
                              + (c - `WF_CENTER_COL);
                    if ((img_r < 0) || (img_r >= `WF_IMAGE_H) ||
                        (img_c < 0) || (img_c >= `WF_IMAGE_W)) begin
                        exp_win_q.push_back(pixel_t'(`WF_BORDER_CONST));
                    end else if (tap_idx < 0) begin
                        exp_win_q.push_back('x);
                    end else begin
                        exp_win_q.push_back(stream_q[tap_idx]);
                    end
                end
            end
        end
    endtask

    // **************************************************
    // Output monitor
    // **************************************************
    task automatic check_outputs();
        logic   exp_valid;
        logic   chk_win;
        pixel_t exp_pix;
        exp_valid = (exp_due_q.size() > 0) && (exp_due_q[0] == cycle);
        if ((dut_valid === 1'b1) && (exp_due_q.size() == 0)) begin
            $display("Error at %0t: valid_o went high with no window expected", $time);
            error_count++;
        end else begin
            check_valid("valid_o", dut_valid, exp_valid);
        end
        if (exp_valid) begin
            check_coord("col_o", dut_col, exp_col_q.pop_front());
            check_coord("row_o", dut_row, exp_row_q.pop_front());
            void'(exp_due_q.pop_front());
            chk_win = exp_chk_q.pop_front();
            for (int r = 0; r < `WF_WIN_H; r++) begin
                for (int c = 0; c < `WF_WIN_W; c++) begin
                    exp_pix = exp_win_q.pop_front();
                    if (chk_win) begin
                        check_pixel($sformatf("window_o[%0d][%0d]", r, c), dut_window[r][c],
                                    exp_pix);
                    end
                end
            end
            windows_seen++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_outputs();
        end
    end

    // **************************************************
    // Main sequence
    // **************************************************
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        data = '0;
        valid = 1'b0;
        frame_start = 1'b0;
        model_pos = StartIdx;
        streaming = 1'b0;
        skip_win = 1'b0;
        void'($urandom(32'h7b1d_72c9));        // Seed once for the whole run
        build_table();

        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NumStim; i++) begin
            repeat (stim_gap[i]) begin
                @(negedge clk);
                valid = 1'b0;
                frame_start = 1'b0;
                data = pixel_t'($urandom);     // Ignored while idle
            end
            @(negedge clk);
            data = stim_pixel[i];
            valid = 1'b1;
            frame_start = stim_sof[i];
            model_push(stim_pixel[i], stim_sof[i], cycle + 3);
        end
        @(negedge clk);
        valid = 1'b0;
        frame_start = 1'b0;
        repeat (4) @(negedge clk);             // Two-cycle latency plus margin

        if (exp_due_q.size() != 0) begin
            $display("Error: %0d expected windows never appeared on valid_o", exp_due_q.size());
            error_count++;
        end
        error_count += u_dut.u_properties.assert_errors;
        $display("Errors: %0d (assertion failures %0d), windows received: %0d",
                 error_count, u_dut.u_properties.assert_errors, windows_seen);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
src/window_pkg.sv
src/center_position_counter.sv
src/window_prime_fsm.sv
src/line_buffer.sv
src/window_shift_array.sv
src/border_extend.sv
src/window_fetch_top.sv
sim/window_fetch_properties.sv
sim/window_fetch_tb.sv

/* Bender.yml */
package:
  name: window_fetch

export_include_dirs:
  - include

sources:
  - files:
      - src/window_pkg.sv
      - src/center_position_counter.sv
      - src/window_prime_fsm.sv
      - src/line_buffer.sv
      - src/window_shift_array.sv
      - src/border_extend.sv
      - src/window_fetch_top.sv
  - target: test
    files:
      - sim/window_fetch_properties.sv
      - sim/window_fetch_tb.sv
